//--- sources.f
hdl/lc3b_issue_pkg.sv
hdl/instr_decode.sv
hdl/operand_resolve.sv
hdl/reg_status.sv
hdl/issue_control.sv
hdl/issue_top.sv
sim/clock_gen.sv
sim/issue_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the issue stage testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/10ps \
	-f sources.f --top-module issue_tb -Mdir obj_dir -o issue_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/issue_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
	exit 1
fi

exit 0

//--- sim/issue_tb.sv
`timescale 1ns/10ps
`default_nettype none

module issue_tb;
	import lc3b_issue_pkg::*;

	localparam int num_cycles = 3000;
	localparam int reset_cycles = 8;
	localparam int watchdog_ns = (num_cycles + reset_cycles) * 4 * 2;

	wire clk;
	wire rst_n;

	// Stimulus, changed on the falling edge
	lc3b_word instr;
	logic instr_is_new;
	lc3b_word curr_pc;
	logic predict_bit;
	logic cdb_valid;
	rob_tag_t cdb_tag;
	lc3b_word cdb_data;
	logic rob_full;
	rob_tag_t rob_addr;
	logic [2:0] rs_busy;
	logic ls_full;
	logic commit_valid;
	lc3b_reg commit_reg;
	rob_tag_t commit_tag;
	lc3b_word commit_data;

	wire stall;
	wire pcmux_sel;
	wire lc3b_word br_pc;
	wire rob_tag_t rob_a_addr;
	wire rob_tag_t rob_b_addr;
	wire rs_write;
	wire [1:0] rs_id;
	wire lc3b_opcode rs_op;
	wire lc3b_word rs_vj;
	wire rs_vj_ready;
	wire rob_tag_t rs_qj;
	wire lc3b_word rs_vk;
	wire rs_vk_ready;
	wire rob_tag_t rs_qk;
	wire ls_write;
	wire lc3b_opcode ls_op;
	wire lc3b_word ls_offset;
	wire lc3b_word ls_base;
	wire ls_base_ready;
	wire rob_tag_t ls_qbase;
	wire lc3b_word ls_src;
	wire ls_src_ready;
	wire rob_tag_t ls_qsrc;
	wire rob_write;
	wire lc3b_opcode rob_op;
	wire lc3b_reg rob_dest;
	wire lc3b_word rob_value;

	// ROB model answers both read ports combinationally
	lc3b_word rob_vals [8];
	logic [7:0] rob_done;
	wire lc3b_word rob_a_value = rob_vals[rob_a_addr];
	wire rob_a_valid = rob_done[rob_a_addr];
	wire lc3b_word rob_b_value = rob_vals[rob_b_addr];
	wire rob_b_valid = rob_done[rob_b_addr];

	// Reference register status table
	lc3b_word m_val [8];
	logic [7:0] m_busy;
	rob_tag_t m_tag [8];
	logic m_bubble;
	rob_tag_t next_tag; // ROB allocation counter
	logic hold; // Fetch keeps the instruction after a stall
	int errors;
	int checks;

	// Expected view of the current cycle
	lc3b_opcode op;
	lc3b_reg sa;
	lc3b_reg sb;
	lc3b_reg e_dest;
	lc3b_word a_v;
	lc3b_word b_v;
	logic a_r;
	logic b_r;
	rob_tag_t a_t;
	rob_tag_t b_t;
	lc3b_word target;
	logic imm;
	logic is_alu;
	logic is_mem;
	logic jsrr;
	logic redirect;
	logic writes_reg;
	logic e_stall;
	logic e_go;
	logic e_rob_write;

	clock_gen #(.reset_cycles(reset_cycles)) u_clock (.clk(clk), .rst_n(rst_n));

	issue_top DUT (.*);

	function automatic lc3b_opcode pick_opcode(input int unsigned n);
		case (n % 10)
			0: return op_add;
			1: return op_and;
			2: return op_not;
			3: return op_shf;
			4: return op_ldr;
			5: return op_str;
			6: return op_br;
			7: return op_jmp;
			8: return op_jsr;
			default: return op_lea;
		endcase
	endfunction

	function automatic logic [1:0] lowest_free(input logic [2:0] busy);
		for (int i = 0; i < 3; i++)
		begin
			if (!busy[i])
				return 2'(i);
		end
		return 2'd2;
	endfunction

	task automatic check_field(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Ready operands carry a value, waiting ones carry a tag
	task automatic check_operand(input string vname, input string qname,
		input lc3b_word got_v, input logic got_r, input rob_tag_t got_q,
		input lc3b_word exp_v, input logic exp_r, input rob_tag_t exp_q);
		check_field({vname, "_ready"}, 16'(got_r), 16'(exp_r));
		if (exp_r)
			check_field(vname, got_v, exp_v);
		else
			check_field(qname, 16'(got_q), 16'(exp_q));
	endtask

	// Register, then CDB, then finished ROB entry, else wait on the tag
	task automatic resolve_operand(input lc3b_reg r, output lc3b_word v,
		output logic rdy, output rob_tag_t t);
		t = m_tag[r];
		rdy = 1'b1;
		v = m_val[r];
		if (m_busy[r])
		begin
			if (cdb_valid && (cdb_tag == m_tag[r]))
				v = cdb_data;
			else if (rob_done[m_tag[r]])
				v = rob_vals[m_tag[r]];
			else
				rdy = 1'b0;
		end
	endtask

	task automatic new_instr();
		lc3b_opcode o;
		o = pick_opcode($urandom);
		instr = {o, 12'($urandom)};
		if (o == op_not)
			instr[5:0] = 6'h3f;
		curr_pc = {15'($urandom), 1'b0};
		predict_bit = 1'($urandom);
	endtask

	task automatic drive_inputs();
		if (!hold)
			new_instr();
		instr_is_new = hold || (($urandom % 8) != 0);
		rob_full = ($urandom % 7) == 0;
		rs_busy = 3'($urandom);
		ls_full = ($urandom % 5) == 0;
		rob_addr = next_tag;
		cdb_valid = ($urandom % 5) < 2;
		cdb_tag = m_tag[3'($urandom)]; // Mostly tags still in flight
		cdb_data = 16'($urandom);
		rob_done = 8'($urandom);
		for (int i = 0; i < 8; i++)
			rob_vals[i] = 16'($urandom);
		commit_valid = ($urandom % 10) < 3;
		commit_reg = 3'($urandom);
		commit_tag = (($urandom % 2) == 0) ? m_tag[commit_reg] : 3'($urandom);
		commit_data = 16'($urandom);
	endtask

	task automatic predict();
		op = instr[15:12];
		sa = instr[8:6];
		sb = (op == op_str) ? instr[11:9] : instr[2:0]; // STR stores from DR
		resolve_operand(sa, a_v, a_r, a_t);
		resolve_operand(sb, b_v, b_r, b_t);
		is_alu = op inside {op_add, op_and, op_not, op_shf};
		is_mem = op inside {op_ldr, op_str};
		jsrr = (op == op_jsr) && !instr[11];
		imm = (is_alu && instr[5]) || (op == op_shf);
		redirect = (op inside {op_jmp, op_jsr}) || ((op == op_br) && predict_bit);
		writes_reg = is_alu || (op inside {op_ldr, op_lea, op_jsr});
		e_dest = (op == op_jsr) ? 3'd7 : instr[11:9];
		if (op == op_jsr)
			target = curr_pc + (lc3b_word'($signed(instr[10:0])) << 1);
		else
			target = curr_pc + (lc3b_word'($signed(instr[8:0])) << 1);
		e_stall = instr_is_new && !m_bubble && (rob_full || (is_alu && (rs_busy == 3'b111))
			|| (is_mem && ls_full) || (((op == op_jmp) || jsrr) && !a_r));
		e_go = instr_is_new && !m_bubble && !e_stall;
		e_rob_write = e_go && (is_alu || is_mem || (op inside {op_br, op_lea, op_jsr}));
	endtask

	task automatic check_outputs();
		lc3b_word exp_rob_value;
		check_field("stall", 16'(stall), 16'(e_stall));
		check_field("pcmux_sel", 16'(pcmux_sel), 16'(e_go && redirect));
		check_field("rs_write", 16'(rs_write), 16'(e_go && is_alu));
		check_field("ls_write", 16'(ls_write), 16'(e_go && is_mem));
		check_field("rob_write", 16'(rob_write), 16'(e_rob_write));
		check_field("rob_a_addr", 16'(rob_a_addr), 16'(m_tag[sa]));
		check_field("rob_b_addr", 16'(rob_b_addr), 16'(m_tag[sb]));
		if (e_go && redirect)
			check_field("br_pc", br_pc, ((op == op_jmp) || jsrr) ? a_v : target);
		if (e_go && is_alu)
		begin
			check_field("rs_id", 16'(rs_id), 16'(lowest_free(rs_busy)));
			check_field("rs_op", 16'(rs_op), 16'(op));
			check_operand("rs_vj", "rs_qj", rs_vj, rs_vj_ready, rs_qj, a_v, a_r, a_t);
			if (imm)
				check_operand("rs_vk", "rs_qk", rs_vk, rs_vk_ready, rs_qk,
					lc3b_word'($signed(instr[4:0])), 1'b1, '0);
			else
				check_operand("rs_vk", "rs_qk", rs_vk, rs_vk_ready, rs_qk, b_v, b_r, b_t);
		end
		if (e_go && is_mem)
		begin
			check_field("ls_op", 16'(ls_op), 16'(op));
			check_field("ls_offset", ls_offset, lc3b_word'($signed(instr[5:0])) << 1);
			check_operand("ls_base", "ls_qbase", ls_base, ls_base_ready, ls_qbase,
				a_v, a_r, a_t);
			if (op == op_str)
				check_operand("ls_src", "ls_qsrc", ls_src, ls_src_ready, ls_qsrc,
					b_v, b_r, b_t);
		end
		if (e_rob_write)
		begin
			check_field("rob_op", 16'(rob_op), 16'(op));
			if (writes_reg)
				check_field("rob_dest", 16'(rob_dest), 16'(e_dest));
			if (op inside {op_br, op_lea, op_jsr})
			begin
				// BR keeps the PC to recover to if the prediction was wrong
				if (op == op_br)
					exp_rob_value = predict_bit ? curr_pc : target;
				else if (op == op_lea)
					exp_rob_value = target;
				else
					exp_rob_value = curr_pc;
				check_field("rob_value", rob_value, exp_rob_value);
			end
		end
	endtask

	task automatic update_model();
		if (commit_valid)
		begin
			m_val[commit_reg] = commit_data;
			if (m_tag[commit_reg] == commit_tag)
				m_busy[commit_reg] = 1'b0; // Stale tags leave busy set
		end
		if (e_go && writes_reg)
		begin
			m_busy[e_dest] = 1'b1; // Applied after commit so the mark wins
			m_tag[e_dest] = next_tag;
		end
		if (e_rob_write)
			next_tag = next_tag + 3'd1;
		m_bubble = e_go && redirect;
		hold = e_stall;
	endtask

	initial
	begin
		#(watchdog_ns * 1ns);
		$display("Timeout after %0d ns, the test loop did not finish", watchdog_ns);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		instr = '0;
		instr_is_new = 1'b0;
		curr_pc = '0;
		predict_bit = 1'b0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		rob_full = 1'b0;
		rob_addr = '0;
		rs_busy = '0;
		ls_full = 1'b0;
		commit_valid = 1'b0;
		commit_reg = '0;
		commit_tag = '0;
		commit_data = '0;
		rob_done = '0;
		m_busy = '0;
		for (int i = 0; i < 8; i++)
		begin
			rob_vals[i] = '0;
			m_val[i] = '0;
			m_tag[i] = '0;
		end
		m_bubble = 1'b0;
		next_tag = '0;
		hold = 1'b0;
		errors = 0;
		checks = 0;
		void'($urandom(89));
		@(posedge rst_n);
		for (int cyc = 0; cyc < num_cycles; cyc++)
		begin
			@(negedge clk);
			drive_inputs();
			predict();
			@(posedge clk);
			check_outputs();
			update_model();
		end
		@(negedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
	parameter int reset_cycles = 8
) (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1; // Released on a falling edge
	end

endmodule

`default_nettype wire

//--- hdl/issue_top.sv
`timescale 1ns/10ps
`default_nettype none

module issue_top #(
	parameter int tag_width = $bits(lc3b_issue_pkg::rob_tag_t)
) (
	input wire clk,
	input wire rst_n,
	// Fetch
	input wire lc3b_issue_pkg::lc3b_word instr,
	input wire instr_is_new,
	input wire lc3b_issue_pkg::lc3b_word curr_pc,
	input wire predict_bit,
	output logic stall,
	output logic pcmux_sel,
	output lc3b_issue_pkg::lc3b_word br_pc,
	// CDB
	input wire cdb_valid,
	input wire [tag_width-1:0] cdb_tag,
	input wire lc3b_issue_pkg::lc3b_word cdb_data,
	// ROB read ports and status
	output logic [tag_width-1:0] rob_a_addr,
	input wire lc3b_issue_pkg::lc3b_word rob_a_value,
	input wire rob_a_valid,
	output logic [tag_width-1:0] rob_b_addr,
	input wire lc3b_issue_pkg::lc3b_word rob_b_value,
	input wire rob_b_valid,
	input wire rob_full,
	input wire [tag_width-1:0] rob_addr,
	input wire [2:0] rs_busy,
	input wire ls_full,
	// Reservation station dispatch
	output logic rs_write,
	output logic [1:0] rs_id,
	output lc3b_issue_pkg::lc3b_opcode rs_op,
	output lc3b_issue_pkg::lc3b_word rs_vj,
	output logic rs_vj_ready,
	output logic [tag_width-1:0] rs_qj,
	output lc3b_issue_pkg::lc3b_word rs_vk,
	output logic rs_vk_ready,
	output logic [tag_width-1:0] rs_qk,
	// Load/store buffer dispatch
	output logic ls_write,
	output lc3b_issue_pkg::lc3b_opcode ls_op,
	output lc3b_issue_pkg::lc3b_word ls_offset,
	output lc3b_issue_pkg::lc3b_word ls_base,
	output logic ls_base_ready,
	output logic [tag_width-1:0] ls_qbase,
	output lc3b_issue_pkg::lc3b_word ls_src,
	output logic ls_src_ready,
	output logic [tag_width-1:0] ls_qsrc,
	// ROB write
	output logic rob_write,
	output lc3b_issue_pkg::lc3b_opcode rob_op,
	output lc3b_issue_pkg::lc3b_reg rob_dest,
	output lc3b_issue_pkg::lc3b_word rob_value,
	// Commit
	input wire commit_valid,
	input wire lc3b_issue_pkg::lc3b_reg commit_reg,
	input wire [tag_width-1:0] commit_tag,
	input wire lc3b_issue_pkg::lc3b_word commit_data
);
	import lc3b_issue_pkg::*;

	lc3b_opcode opcode;
	lc3b_reg dest_reg;
	lc3b_reg src_a_reg;
	lc3b_reg src_b_reg;
	logic imm_valid;
	logic jsr_imm;
	lc3b_word imm5;
	lc3b_word offset6;
	lc3b_word pc_rel_target;
	// Register status read ports
	lc3b_word rf_a_value;
	lc3b_word rf_b_value;
	logic rf_a_busy;
	logic rf_b_busy;
	logic [tag_width-1:0] rf_a_tag;
	logic [tag_width-1:0] rf_b_tag;
	// Resolved operands
	lc3b_word a_value;
	lc3b_word b_value;
	logic a_ready;
	logic b_ready;
	logic [tag_width-1:0] a_tag;
	logic [tag_width-1:0] b_tag;
	logic mark_busy;
	lc3b_reg mark_reg;
	logic [tag_width-1:0] mark_tag;

	instr_decode u_decode (
		.instr(instr),
		.curr_pc(curr_pc),
		.opcode(opcode),
		.dest_reg(dest_reg),
		.src_a_reg(src_a_reg),
		.src_b_reg(src_b_reg),
		.imm_valid(imm_valid),
		.imm5(imm5),
		.offset6(offset6),
		.pc_rel_target(pc_rel_target),
		.jsr_imm(jsr_imm)
	);

	reg_status #(.tag_width(tag_width)) u_reg_status (
		.clk(clk),
		.rst_n(rst_n),
		.rd_a(src_a_reg),
		.rd_b(src_b_reg),
		.a_value(rf_a_value),
		.a_busy(rf_a_busy),
		.a_tag(rf_a_tag),
		.b_value(rf_b_value),
		.b_busy(rf_b_busy),
		.b_tag(rf_b_tag),
		.mark_busy(mark_busy),
		.mark_reg(mark_reg),
		.mark_tag(mark_tag),
		.commit_valid(commit_valid),
		.commit_reg(commit_reg),
		.commit_tag(commit_tag),
		.commit_data(commit_data)
	);

	operand_resolve #(.tag_width(tag_width)) opnd_a (
		.reg_value(rf_a_value),
		.reg_busy(rf_a_busy),
		.reg_tag(rf_a_tag),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.rob_value(rob_a_value),
		.rob_valid(rob_a_valid),
		.rob_addr(rob_a_addr),
		.value(a_value),
		.ready(a_ready),
		.tag(a_tag)
	);

	operand_resolve #(.tag_width(tag_width)) opnd_b (
		.reg_value(rf_b_value),
		.reg_busy(rf_b_busy),
		.reg_tag(rf_b_tag),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.rob_value(rob_b_value),
		.rob_valid(rob_b_valid),
		.rob_addr(rob_b_addr),
		.value(b_value),
		.ready(b_ready),
		.tag(b_tag)
	);

	issue_control #(.tag_width(tag_width)) u_control (
		.clk(clk),
		.rst_n(rst_n),
		.instr_is_new(instr_is_new),
		.predict_bit(predict_bit),
		.curr_pc(curr_pc),
		.opcode(opcode),
		.dest_reg(dest_reg),
		.imm_valid(imm_valid),
		.imm5(imm5),
		.offset6(offset6),
		.pc_rel_target(pc_rel_target),
		.jsr_imm(jsr_imm),
		.a_value(a_value),
		.a_ready(a_ready),
		.a_tag(a_tag),
		.b_value(b_value),
		.b_ready(b_ready),
		.b_tag(b_tag),
		.rob_full(rob_full),
		.rob_addr(rob_addr),
		.rs_busy(rs_busy),
		.ls_full(ls_full),
		.stall(stall),
		.pcmux_sel(pcmux_sel),
		.br_pc(br_pc),
		.rs_write(rs_write),
		.rs_id(rs_id),
		.rs_op(rs_op),
		.rs_vj(rs_vj),
		.rs_vj_ready(rs_vj_ready),
		.rs_qj(rs_qj),
		.rs_vk(rs_vk),
		.rs_vk_ready(rs_vk_ready),
		.rs_qk(rs_qk),
		.ls_write(ls_write),
		.ls_op(ls_op),
		.ls_offset(ls_offset),
		.ls_base(ls_base),
		.ls_base_ready(ls_base_ready),
		.ls_qbase(ls_qbase),
		.ls_src(ls_src),
		.ls_src_ready(ls_src_ready),
		.ls_qsrc(ls_qsrc),
		.rob_write(rob_write),
		.rob_op(rob_op),
		.rob_dest(rob_dest),
		.rob_value(rob_value),
		.mark_busy(mark_busy),
		.mark_reg(mark_reg),
		.mark_tag(mark_tag)
	);

endmodule

`default_nettype wire

//--- hdl/issue_control.sv
`timescale 1ns/10ps
`default_nettype none

module issue_control #(
	parameter int tag_width = $bits(lc3b_issue_pkg::rob_tag_t)
) (
	input wire clk,
	input wire rst_n,
	input wire instr_is_new,
	input wire predict_bit,
	input wire lc3b_issue_pkg::lc3b_word curr_pc,
	// Decoder
	input wire lc3b_issue_pkg::lc3b_opcode opcode,
	input wire lc3b_issue_pkg::lc3b_reg dest_reg,
	input wire imm_valid,
	input wire lc3b_issue_pkg::lc3b_word imm5,
	input wire lc3b_issue_pkg::lc3b_word offset6,
	input wire lc3b_issue_pkg::lc3b_word pc_rel_target,
	input wire jsr_imm,
	// Resolved operands
	input wire lc3b_issue_pkg::lc3b_word a_value,
	input wire a_ready,
	input wire [tag_width-1:0] a_tag,
	input wire lc3b_issue_pkg::lc3b_word b_value,
	input wire b_ready,
	input wire [tag_width-1:0] b_tag,
	// Back-end status
	input wire rob_full,
	input wire [tag_width-1:0] rob_addr,
	input wire [2:0] rs_busy,
	input wire ls_full,
	// To fetch
	output logic stall,
	output logic pcmux_sel,
	output lc3b_issue_pkg::lc3b_word br_pc,
	// ALU reservation stations
	output logic rs_write,
	output logic [1:0] rs_id,
	output lc3b_issue_pkg::lc3b_opcode rs_op,
	output lc3b_issue_pkg::lc3b_word rs_vj,
	output logic rs_vj_ready,
	output logic [tag_width-1:0] rs_qj,
	output lc3b_issue_pkg::lc3b_word rs_vk,
	output logic rs_vk_ready,
	output logic [tag_width-1:0] rs_qk,
	// Load/store buffer
	output logic ls_write,
	output lc3b_issue_pkg::lc3b_opcode ls_op,
	output lc3b_issue_pkg::lc3b_word ls_offset,
	output lc3b_issue_pkg::lc3b_word ls_base,
	output logic ls_base_ready,
	output logic [tag_width-1:0] ls_qbase,
	output lc3b_issue_pkg::lc3b_word ls_src,
	output logic ls_src_ready,
	output logic [tag_width-1:0] ls_qsrc,
	// ROB allocation
	output logic rob_write,
	output lc3b_issue_pkg::lc3b_opcode rob_op,
	output lc3b_issue_pkg::lc3b_reg rob_dest,
	output lc3b_issue_pkg::lc3b_word rob_value,
	// Register status
	output logic mark_busy,
	output lc3b_issue_pkg::lc3b_reg mark_reg,
	output logic [tag_width-1:0] mark_tag
);
	import lc3b_issue_pkg::*;

	logic bubble; // Fetch is refilling after a redirect
	logic is_alu;
	logic is_mem;
	logic needs_base;
	logic redirect;
	logic blocked;
	logic go;
	logic writes_reg;
	lc3b_reg dest_or_link;

	assign is_alu = (opcode == op_add) || (opcode == op_and) || (opcode == op_not)
		|| (opcode == op_shf);
	assign is_mem = (opcode == op_ldr) || (opcode == op_str);
	assign needs_base = (opcode == op_jmp) || ((opcode == op_jsr) && !jsr_imm);
	assign redirect = (opcode == op_jmp) || (opcode == op_jsr)
		|| ((opcode == op_br) && predict_bit);
	assign writes_reg = is_alu || (opcode == op_ldr) || (opcode == op_lea)
		|| (opcode == op_jsr);

	// Structural hazards, plus indirect jumps waiting for their base
	assign blocked = rob_full || (is_alu && (&rs_busy)) || (is_mem && ls_full)
		|| (needs_base && !a_ready);

	assign stall = instr_is_new && !bubble && blocked;
	assign go = instr_is_new && !bubble && !blocked;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			bubble <= 1'b0;
		else
			bubble <= go && redirect; // Lasts exactly one cycle
	end

	assign pcmux_sel = go && redirect;
	assign br_pc = needs_base ? a_value : pc_rel_target;

	assign rs_write = go && is_alu;
	assign rs_op = opcode;

	// Lowest free station wins
	always_comb
	begin
		if (!rs_busy[0])
			rs_id = 2'd0;
		else if (!rs_busy[1])
			rs_id = 2'd1;
		else
			rs_id = 2'd2;
	end

	assign rs_vj = a_value;
	assign rs_vj_ready = a_ready;
	assign rs_qj = a_tag;
	assign rs_vk = imm_valid ? imm5 : b_value;
	assign rs_vk_ready = imm_valid || b_ready;
	assign rs_qk = imm_valid ? '0 : b_tag;

	assign ls_write = go && is_mem;
	assign ls_op = opcode;
	assign ls_offset = offset6;
	assign ls_base = a_value;
	assign ls_base_ready = a_ready;
	assign ls_qbase = a_tag;
	assign ls_src = b_value; // DR contents for STR
	assign ls_src_ready = b_ready;
	assign ls_qsrc = b_tag;

	assign dest_or_link = (opcode == op_jsr) ? lc3b_reg'(7) : dest_reg;

	// JMP needs no ROB entry
	assign rob_write = go && (is_alu || is_mem || (opcode == op_br) || (opcode == op_lea)
		|| (opcode == op_jsr));
	assign rob_op = opcode;
	assign rob_dest = dest_or_link;

	always_comb
	begin
		case (opcode)
			op_br: rob_value = predict_bit ? curr_pc : pc_rel_target; // Recovery PC
			op_lea: rob_value = pc_rel_target;
			op_jsr: rob_value = curr_pc; // Return address for R7
			default: rob_value = '0;
		endcase
	end

	assign mark_busy = go && writes_reg;
	assign mark_reg = dest_or_link;
	assign mark_tag = rob_addr;

endmodule

`default_nettype wire

//--- hdl/reg_status.sv
`timescale 1ns/10ps
`default_nettype none

module reg_status #(
	parameter int tag_width = $bits(lc3b_issue_pkg::rob_tag_t)
) (
	input wire clk,
	input wire rst_n,
	// Read ports
	input wire lc3b_issue_pkg::lc3b_reg rd_a,
	input wire lc3b_issue_pkg::lc3b_reg rd_b,
	output lc3b_issue_pkg::lc3b_word a_value,
	output logic a_busy,
	output logic [tag_width-1:0] a_tag,
	output lc3b_issue_pkg::lc3b_word b_value,
	output logic b_busy,
	output logic [tag_width-1:0] b_tag,
	// Issue marks the destination as pending
	input wire mark_busy,
	input wire lc3b_issue_pkg::lc3b_reg mark_reg,
	input wire [tag_width-1:0] mark_tag,
	// Commit from the ROB head
	input wire commit_valid,
	input wire lc3b_issue_pkg::lc3b_reg commit_reg,
	input wire [tag_width-1:0] commit_tag,
	input wire lc3b_issue_pkg::lc3b_word commit_data
);
	import lc3b_issue_pkg::*;

	lc3b_word reg_val [8];
	logic [7:0] reg_busy;
	logic [tag_width-1:0] reg_tag [8];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 8; i++)
			begin
				reg_val[i] <= '0;
				reg_tag[i] <= '0;
			end
			reg_busy <= '0;
		end
		else
		begin
			if (commit_valid)
			begin
				reg_val[commit_reg] <= commit_data;
				// A newer writer keeps the register busy
				if (reg_tag[commit_reg] == commit_tag)
					reg_busy[commit_reg] <= 1'b0;
			end
			// Placed last so a same-cycle mark beats the commit
			if (mark_busy)
			begin
				reg_busy[mark_reg] <= 1'b1;
				reg_tag[mark_reg] <= mark_tag;
			end
		end
	end

	// Reads see the contents before this edge's updates
	assign a_value = reg_val[rd_a];
	assign a_busy = reg_busy[rd_a];
	assign a_tag = reg_tag[rd_a];
	assign b_value = reg_val[rd_b];
	assign b_busy = reg_busy[rd_b];
	assign b_tag = reg_tag[rd_b];

endmodule

`default_nettype wire

//--- hdl/operand_resolve.sv
`timescale 1ns/10ps
`default_nettype none

module operand_resolve #(
	parameter int tag_width = $bits(lc3b_issue_pkg::rob_tag_t)
) (
	// From register status
	input wire lc3b_issue_pkg::lc3b_word reg_value,
	input wire reg_busy,
	input wire [tag_width-1:0] reg_tag,
	// Common data bus
	input wire cdb_valid,
	input wire [tag_width-1:0] cdb_tag,
	input wire lc3b_issue_pkg::lc3b_word cdb_data,
	// ROB read port answer
	input wire lc3b_issue_pkg::lc3b_word rob_value,
	input wire rob_valid,
	output logic [tag_width-1:0] rob_addr,
	output lc3b_issue_pkg::lc3b_word value,
	output logic ready,
	output logic [tag_width-1:0] tag
);

	assign rob_addr = reg_tag; // Look up the producer's entry

	always_comb
	begin
		value = reg_value;
		ready = 1'b1;
		tag = '0;
		if (!reg_busy)
		begin
			value = reg_value; // Architectural value is current
		end
		else if (cdb_valid && (cdb_tag == reg_tag))
		begin
			value = cdb_data; // Broadcast this cycle
		end
		else if (rob_valid)
		begin
			value = rob_value; // Finished but not yet committed
		end
		else
		begin
			// Still in flight, wait on the tag
			value = '0;
			ready = 1'b0;
			tag = reg_tag;
		end
	end

endmodule

`default_nettype wire

//--- hdl/instr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decode (
	input wire lc3b_issue_pkg::lc3b_word instr,
	input wire lc3b_issue_pkg::lc3b_word curr_pc,
	output lc3b_issue_pkg::lc3b_opcode opcode,
	output lc3b_issue_pkg::lc3b_reg dest_reg,
	output lc3b_issue_pkg::lc3b_reg src_a_reg,
	output lc3b_issue_pkg::lc3b_reg src_b_reg,
	output logic imm_valid,
	output lc3b_issue_pkg::lc3b_word imm5,
	output lc3b_issue_pkg::lc3b_word offset6,
	output lc3b_issue_pkg::lc3b_word pc_rel_target,
	output logic jsr_imm
);
	import lc3b_issue_pkg::*;

	lc3b_word off9; // PCoffset9, word aligned
	lc3b_word off11; // PCoffset11 for JSR
	logic alu_imm_form;

	assign opcode = instr[15:12];
	assign dest_reg = instr[11:9];
	assign src_a_reg = instr[8:6]; // SR1 or BaseR

	// STR reads its store data through the DR field
	assign src_b_reg = (opcode == op_str) ? instr[11:9] : instr[2:0];

	assign jsr_imm = instr[11]; // 1 for JSR, 0 for JSRR

	// NOT is encoded with bit 5 set, so it takes the all-ones immediate
	assign alu_imm_form = ((opcode == op_add) || (opcode == op_and) || (opcode == op_not))
		&& instr[5];
	assign imm_valid = alu_imm_form || (opcode == op_shf);

	assign imm5 = {{11{instr[4]}}, instr[4:0]};
	assign offset6 = {{9{instr[5]}}, instr[5:0], 1'b0};
	assign off9 = {{6{instr[8]}}, instr[8:0], 1'b0};
	assign off11 = {{4{instr[10]}}, instr[10:0], 1'b0};

	// BR, LEA and JSR all add to the current PC
	assign pc_rel_target = curr_pc + ((opcode == op_jsr) ? off11 : off9);

endmodule

`default_nettype wire

//--- hdl/lc3b_issue_pkg.sv
`default_nettype none

package lc3b_issue_pkg;

	// Data and PC word
	typedef logic [15:0] lc3b_word;

	// Architectural register number, R0 to R7
	typedef logic [2:0] lc3b_reg;

	typedef logic [3:0] lc3b_opcode; // instr[15:12]

	// ROB entry tag, eight entries by default
	typedef logic [2:0] rob_tag_t;

	// Opcodes handled by the issue stage
	localparam lc3b_opcode op_br = 4'b0000;
	localparam lc3b_opcode op_add = 4'b0001;
	localparam lc3b_opcode op_jsr = 4'b0100; // JSR and JSRR
	localparam lc3b_opcode op_and = 4'b0101;
	localparam lc3b_opcode op_ldr = 4'b0110;
	localparam lc3b_opcode op_str = 4'b0111;
	localparam lc3b_opcode op_not = 4'b1001;
	localparam lc3b_opcode op_jmp = 4'b1100; // Also RET
	localparam lc3b_opcode op_shf = 4'b1101;
	localparam lc3b_opcode op_lea = 4'b1110;

endpackage

`default_nettype wire
